//--- pixelPkg.sv
/*
 * Shared definitions for the pixel pipeline
 * Channel, position, depth and texture address widths
 * Stage latencies and fog table geometry
 * Config word field positions and tex-env mode codes
 * Sideband record carried alongside the colour
 */
package pixelPkg;

    //////////////////////////////
    // Widths
    //////////////////////////////
    localparam int subPixelWidth  = 8;
    // R, G, B, A from the top
    localparam int pixelWidth     = 4 * subPixelWidth;
    localparam int indexWidth     = 14;
    localparam int screenPosWidth = 11;
    // Q16.16
    localparam int depthWidth     = 32;
    // S16.15
    localparam int texCoordWidth  = 32;
    localparam int texAddrWidth   = 17;

    //////////////////////////////
    // Latencies
    //////////////////////////////
    localparam int texLatency  = 3;
    localparam int fogLatency  = 2;
    localparam int pipeLatency = texLatency + fogLatency;

    // Fog table
    localparam int fogLutDepth     = 64;
    localparam int fogLutAddrWidth = 6;

    //////////////////////////////
    // Config fields and modes
    //////////////////////////////
    localparam int featureEnableTexPos = 0;
    localparam int featureEnableFogPos = 1;
    localparam int texWidthLog2Pos     = 0;
    localparam int texHeightLog2Pos    = 4;
    localparam int texEnvFuncPos       = 0;

    localparam logic [1:0] texEnvReplace  = 2'd0;
    localparam logic [1:0] texEnvModulate = 2'd1;
    localparam logic [1:0] texEnvAdd      = 2'd2;

    // Sideband fields that ride along with the colour
    typedef struct packed {
        logic                      valid;
        logic                      last;
        logic                      keep;
        logic [indexWidth-1:0]     index;
        logic [screenPosWidth-1:0] screenX;
        logic [screenPosWidth-1:0] screenY;
        logic [depthWidth-1:0]     depth;
    } fragSideband_t;

endpackage

//--- valueDelay.sv
/*
 * Clock-enabled delay line
 * Payload type and number of stages are parameters
 */
module valueDelay #(
    parameter type T     = logic,
    parameter int  depth = 1
)
(
    input  logic aclk,
    input  logic rstN,
    input  logic ce,
    input  T     in,
    output T     out
);

    T stages [depth];

    // Whole chain shifts by one on each enabled edge
    always_ff @(posedge aclk or negedge rstN)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < depth; i++)
            begin
                stages[i] <= '0;
            end
        end
        else if (ce)
        begin
            stages[0] <= in;
            for (int i = 1; i < depth; i++)
            begin
                stages[i] <= stages[i - 1];
            end
        end
    end

    assign out = stages[depth - 1];

endmodule

//--- textureStage.sv
/*
 * Single texture mapping unit
 * Nearest texel address with repeat wrap
 * Texture environment: replace, modulate, saturating add
 */
module textureStage
(
    input  logic                               aclk,
    input  logic                               rstN,
    input  logic                               ce,

    input  logic                               confEnable,
    input  logic [31:0]                        confTextureConfig,
    input  logic [31:0]                        confTexEnvConfig,

    input  logic [pixelPkg::pixelWidth-1:0]    primaryColor,
    input  logic [pixelPkg::texCoordWidth-1:0] textureS,
    input  logic [pixelPkg::texCoordWidth-1:0] textureT,

    output logic [pixelPkg::texAddrWidth-1:0]  texelAddr,
    input  logic [pixelPkg::pixelWidth-1:0]    texelInput,

    output logic [pixelPkg::pixelWidth-1:0]    fragmentColor
);

    //////////////////////////////
    // Stage 1: texel address
    //////////////////////////////
    logic [3:0]  widthLog2;
    logic [3:0]  heightLog2;
    logic [14:0] sColumn;
    logic [14:0] tRow;
    logic [pixelPkg::texAddrWidth-1:0] rowOffset;
    logic [pixelPkg::pixelWidth-1:0]   primaryColorS1;

    assign widthLog2  = confTextureConfig[pixelPkg::texWidthLog2Pos +: 4];
    assign heightLog2 = confTextureConfig[pixelPkg::texHeightLog2Pos +: 4];

    // Top bits of the 15 fraction bits; the integer part wraps away
    assign sColumn = textureS[14:0] >> (4'd15 - widthLog2);
    assign tRow    = textureT[14:0] >> (4'd15 - heightLog2);

    assign rowOffset = {{(pixelPkg::texAddrWidth - 15){1'b0}}, tRow} << widthLog2;

    always_ff @(posedge aclk or negedge rstN)
    begin
        if (!rstN)
        begin
            texelAddr <= '0;
        end
        else if (ce)
        begin
            texelAddr <= rowOffset | {{(pixelPkg::texAddrWidth - 15){1'b0}}, sColumn};
        end
    end

    //////////////////////////////
    // Stage 2: texel capture
    //////////////////////////////
    logic [pixelPkg::pixelWidth-1:0] texelS2;
    logic [pixelPkg::pixelWidth-1:0] primaryColorS2;

    // Memory answers within the same cycle as the address
    always_ff @(posedge aclk)
    begin
        if (ce)
        begin
            primaryColorS1 <= primaryColor;
            primaryColorS2 <= primaryColorS1;
            texelS2        <= texelInput;
        end
    end

    //////////////////////////////
    // Stage 3: tex-env combine
    //////////////////////////////
    function automatic logic [pixelPkg::pixelWidth-1:0] texEnv(
        input logic [1:0]                      func,
        input logic [pixelPkg::pixelWidth-1:0] texel,
        input logic [pixelPkg::pixelWidth-1:0] primary
    );
        logic [pixelPkg::subPixelWidth-1:0]   t;
        logic [pixelPkg::subPixelWidth-1:0]   p;
        logic [2*pixelPkg::subPixelWidth-1:0] product;
        logic [pixelPkg::subPixelWidth:0]     sum;
        logic [pixelPkg::pixelWidth-1:0]      result;
        result = texel;
        for (int ch = 0; ch < 4; ch++)
        begin
            t       = texel[ch*pixelPkg::subPixelWidth +: pixelPkg::subPixelWidth];
            p       = primary[ch*pixelPkg::subPixelWidth +: pixelPkg::subPixelWidth];
            product = {{pixelPkg::subPixelWidth{1'b0}}, t} * {{pixelPkg::subPixelWidth{1'b0}}, p};
            sum     = {1'b0, t} + {1'b0, p};
            case (func)
                pixelPkg::texEnvModulate:
                    result[ch*pixelPkg::subPixelWidth +: pixelPkg::subPixelWidth] =
                        product[2*pixelPkg::subPixelWidth-1 -: pixelPkg::subPixelWidth];
                pixelPkg::texEnvAdd:
                    // Clip at full scale
                    result[ch*pixelPkg::subPixelWidth +: pixelPkg::subPixelWidth] =
                        sum[pixelPkg::subPixelWidth] ? '1 : sum[pixelPkg::subPixelWidth-1:0];
                default:
                    result[ch*pixelPkg::subPixelWidth +: pixelPkg::subPixelWidth] = t;
            endcase
        end
        return result;
    endfunction

    always_ff @(posedge aclk)
    begin
        if (ce)
        begin
            if (confEnable)
            begin
                fragmentColor <= texEnv(confTexEnvConfig[pixelPkg::texEnvFuncPos +: 2],
                                        texelS2, primaryColorS2);
            end
            else
            begin
                fragmentColor <= primaryColorS2;
            end
        end
    end

endmodule

//--- fogLut.sv
/*
 * Fog factor table
 * Loaded four factors per 32-bit stream word
 * Registered read on the clock enable
 */
module fogLut
(
    input  logic                                 aclk,
    input  logic                                 rstN,

    input  logic                                 lutValid,
    input  logic                                 lutLast,
    input  logic [31:0]                          lutData,

    input  logic                                 ce,
    input  logic [pixelPkg::fogLutAddrWidth-1:0] readAddr,
    output logic [7:0]                           factor
);

    logic [7:0] factorTable [pixelPkg::fogLutDepth];
    logic [pixelPkg::fogLutAddrWidth-1:0] writePtr;

    // Write pointer returns to zero after the last word
    always_ff @(posedge aclk or negedge rstN)
    begin
        if (!rstN)
        begin
            writePtr <= '0;
        end
        else if (lutValid)
        begin
            writePtr <= lutLast ? '0 : writePtr + pixelPkg::fogLutAddrWidth'(4);
        end
    end

    // Lowest byte lands at the pointer
    always_ff @(posedge aclk)
    begin
        if (lutValid)
        begin
            for (int i = 0; i < 4; i++)
            begin
                factorTable[writePtr + pixelPkg::fogLutAddrWidth'(i)] <= lutData[i*8 +: 8];
            end
        end
    end

    always_ff @(posedge aclk)
    begin
        if (ce)
        begin
            factor <= factorTable[readAddr];
        end
    end

endmodule

//--- fogStage.sv
/*
 * Fog stage
 * Table lookup on integer depth, then blend toward the fog colour
 */
module fogStage
(
    input  logic                            aclk,
    input  logic                            rstN,
    input  logic                            ce,

    input  logic                            confEnable,
    input  logic [pixelPkg::pixelWidth-1:0] confFogColor,

    input  logic                            lutValid,
    input  logic                            lutLast,
    input  logic [31:0]                     lutData,

    input  logic [pixelPkg::depthWidth-1:0] depth,
    input  logic [pixelPkg::pixelWidth-1:0] color,

    output logic [pixelPkg::pixelWidth-1:0] fogColor
);

    logic [7:0]                      factor;
    logic [pixelPkg::pixelWidth-1:0] colorS1;

    // Cycle 1: low six integer bits of Q16.16 depth index the table
    fogLut lut (
        .aclk(aclk),
        .rstN(rstN),
        .lutValid(lutValid),
        .lutLast(lutLast),
        .lutData(lutData),
        .ce(ce),
        .readAddr(depth[16 +: pixelPkg::fogLutAddrWidth]),
        .factor(factor)
    );

    always_ff @(posedge aclk)
    begin
        if (ce)
        begin
            colorS1 <= color;
        end
    end

    // f * c + (255 - f) * fog, never above 255 * 255
    function automatic logic [pixelPkg::pixelWidth-1:0] blend(
        input logic [7:0]                      f,
        input logic [pixelPkg::pixelWidth-1:0] c,
        input logic [pixelPkg::pixelWidth-1:0] fog
    );
        logic [7:0]                      inverse;
        logic [15:0]                     sum;
        logic [pixelPkg::pixelWidth-1:0] result;
        inverse = 8'd255 - f;
        for (int ch = 0; ch < 4; ch++)
        begin
            sum = {8'd0, f} * {8'd0, c[ch*8 +: 8]} + {8'd0, inverse} * {8'd0, fog[ch*8 +: 8]};
            result[ch*8 +: 8] = sum[15:8];
        end
        return result;
    endfunction

    // Cycle 2
    always_ff @(posedge aclk)
    begin
        if (ce)
        begin
            fogColor <= confEnable ? blend(factor, colorS1, confFogColor) : colorS1;
        end
    end

endmodule

//--- pixelPipeline.sv
/*
 * Pixel pipeline top level
 * Texturing, then fog, with sideband and fog depth delay lines
 * Whole pipe advances while the output is ready
 */
module pixelPipeline
(
    input  logic                                aclk,
    input  logic                                rstN,

    // Fog table stream
    input  logic                                s_fog_lut_axis_tvalid,
    input  logic                                s_fog_lut_axis_tlast,
    input  logic [31:0]                         s_fog_lut_axis_tdata,

    // Configuration
    input  logic [31:0]                         confFeatureEnable,
    input  logic [31:0]                         confTextureConfig,
    input  logic [31:0]                         confTexEnvConfig,
    input  logic [pixelPkg::pixelWidth-1:0]     confFogColor,

    // Fragment input
    output logic                                s_attrb_tready,
    input  logic                                s_attrb_tvalid,
    input  logic                                s_attrb_tlast,
    input  logic                                s_attrb_tkeep,
    input  logic [pixelPkg::screenPosWidth-1:0] s_attrb_tspx,
    input  logic [pixelPkg::screenPosWidth-1:0] s_attrb_tspy,
    input  logic [pixelPkg::indexWidth-1:0]     s_attrb_tindex,
    input  logic [pixelPkg::depthWidth-1:0]     s_attrb_tdepth_z,
    input  logic [pixelPkg::texCoordWidth-1:0]  s_attrb_ttexture_s,
    input  logic [pixelPkg::texCoordWidth-1:0]  s_attrb_ttexture_t,
    input  logic [pixelPkg::subPixelWidth-1:0]  s_attrb_tcolor_r,
    input  logic [pixelPkg::subPixelWidth-1:0]  s_attrb_tcolor_g,
    input  logic [pixelPkg::subPixelWidth-1:0]  s_attrb_tcolor_b,
    input  logic [pixelPkg::subPixelWidth-1:0]  s_attrb_tcolor_a,

    // Texture memory
    output logic [pixelPkg::texAddrWidth-1:0]   texelAddr,
    input  logic [pixelPkg::pixelWidth-1:0]     texelInput,

    // Fragment output
    input  logic                                m_frag_tready,
    output logic [pixelPkg::pixelWidth-1:0]     m_frag_tfragmentColor,
    output logic [pixelPkg::indexWidth-1:0]     m_frag_tindex,
    output logic [pixelPkg::screenPosWidth-1:0] m_frag_tscreenPosX,
    output logic [pixelPkg::screenPosWidth-1:0] m_frag_tscreenPosY,
    output logic [pixelPkg::depthWidth-1:0]     m_frag_tdepth,
    output logic                                m_frag_tvalid,
    output logic                                m_frag_tlast,
    output logic                                m_frag_tkeep
);

    logic ce;
    assign ce             = m_frag_tready;
    assign s_attrb_tready = m_frag_tready;

    //////////////////////////////
    // Sideband
    //////////////////////////////
    pixelPkg::fragSideband_t sidebandIn;
    pixelPkg::fragSideband_t sidebandOut;

    assign sidebandIn = '{
        valid:   s_attrb_tvalid,
        last:    s_attrb_tlast,
        keep:    s_attrb_tkeep,
        index:   s_attrb_tindex,
        screenX: s_attrb_tspx,
        screenY: s_attrb_tspy,
        depth:   s_attrb_tdepth_z
    };

    valueDelay #(.T(pixelPkg::fragSideband_t), .depth(pixelPkg::pipeLatency)) sidebandDelay (
        .aclk(aclk), .rstN(rstN), .ce(ce), .in(sidebandIn), .out(sidebandOut)
    );

    //////////////////////////////
    // Texturing
    //////////////////////////////
    logic [pixelPkg::pixelWidth-1:0] texColor;
    logic [pixelPkg::depthWidth-1:0] fogDepth;

    textureStage tmu (
        .aclk(aclk),
        .rstN(rstN),
        .ce(ce),
        .confEnable(confFeatureEnable[pixelPkg::featureEnableTexPos]),
        .confTextureConfig(confTextureConfig),
        .confTexEnvConfig(confTexEnvConfig),
        .primaryColor({s_attrb_tcolor_r, s_attrb_tcolor_g, s_attrb_tcolor_b, s_attrb_tcolor_a}),
        .textureS(s_attrb_ttexture_s),
        .textureT(s_attrb_ttexture_t),
        .texelAddr(texelAddr),
        .texelInput(texelInput),
        .fragmentColor(texColor)
    );

    // Depth meets the textured colour at the fog input
    valueDelay #(.T(logic [pixelPkg::depthWidth-1:0]), .depth(pixelPkg::texLatency)) depthDelay (
        .aclk(aclk), .rstN(rstN), .ce(ce), .in(s_attrb_tdepth_z), .out(fogDepth)
    );

    //////////////////////////////
    // Fog
    //////////////////////////////
    fogStage fog (
        .aclk(aclk),
        .rstN(rstN),
        .ce(ce),
        .confEnable(confFeatureEnable[pixelPkg::featureEnableFogPos]),
        .confFogColor(confFogColor),
        .lutValid(s_fog_lut_axis_tvalid),
        .lutLast(s_fog_lut_axis_tlast),
        .lutData(s_fog_lut_axis_tdata),
        .depth(fogDepth),
        .color(texColor),
        .fogColor(m_frag_tfragmentColor)
    );

    assign m_frag_tindex      = sidebandOut.index;
    assign m_frag_tscreenPosX = sidebandOut.screenX;
    assign m_frag_tscreenPosY = sidebandOut.screenY;
    assign m_frag_tdepth      = sidebandOut.depth;
    assign m_frag_tvalid      = sidebandOut.valid;
    assign m_frag_tlast       = sidebandOut.last;
    assign m_frag_tkeep       = sidebandOut.keep;

endmodule

//--- tbClock.sv
/*
 * Testbench clock and reset generator
 * Reset is held low for a fixed number of cycles
 */
module tbClock #(
    parameter int period      = 10,
    parameter int resetCycles = 16
)
(
    output logic aclk,
    output logic rstN
);

    initial
    begin
        aclk = 1'b0;
        forever
        begin
            #(period / 2);
            aclk = ~aclk;
        end
    end

    // Release away from the clock edge
    initial
    begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge aclk);
        #2;
        rstN = 1'b1;
    end

endmodule

//--- pixelPipelineTb.sv
/*
 * Testbench for the pixel pipeline
 * Texture memory, fog table loader and reference model
 * Checks colour, sideband, latency and stall freeze
 */
module pixelPipelineTb;

    localparam int clockPeriod       = 10;
    localparam int driveDelay        = 1;
    localparam int phaseCount        = 8;
    localparam int fragmentsPerPhase = 60;
    localparam int maxStallPerSlot   = 4;
    localparam int fragmentCount     = phaseCount * fragmentsPerPhase;
    localparam int stallCycles       = fragmentCount * maxStallPerSlot;
    localparam int watchdogTime      = (fragmentCount + stallCycles + 200) * clockPeriod;
    localparam int outputBits        = pixelPkg::pixelWidth + pixelPkg::indexWidth
                                       + 2 * pixelPkg::screenPosWidth + pixelPkg::depthWidth + 3;

    typedef struct packed {
        pixelPkg::fragSideband_t         side;
        logic [pixelPkg::pixelWidth-1:0] color;
        int                              dueEdge;
    } expectedFrag_t;

    logic aclk;
    logic rstN;
    logic s_fog_lut_axis_tvalid;
    logic s_fog_lut_axis_tlast;
    logic [31:0] s_fog_lut_axis_tdata;
    logic [31:0] confFeatureEnable;
    logic [31:0] confTextureConfig;
    logic [31:0] confTexEnvConfig;
    logic [pixelPkg::pixelWidth-1:0] confFogColor;
    logic s_attrb_tready;
    logic s_attrb_tvalid;
    logic s_attrb_tlast;
    logic s_attrb_tkeep;
    logic [pixelPkg::screenPosWidth-1:0] s_attrb_tspx;
    logic [pixelPkg::screenPosWidth-1:0] s_attrb_tspy;
    logic [pixelPkg::indexWidth-1:0] s_attrb_tindex;
    logic [pixelPkg::depthWidth-1:0] s_attrb_tdepth_z;
    logic [pixelPkg::texCoordWidth-1:0] s_attrb_ttexture_s;
    logic [pixelPkg::texCoordWidth-1:0] s_attrb_ttexture_t;
    logic [pixelPkg::subPixelWidth-1:0] s_attrb_tcolor_r;
    logic [pixelPkg::subPixelWidth-1:0] s_attrb_tcolor_g;
    logic [pixelPkg::subPixelWidth-1:0] s_attrb_tcolor_b;
    logic [pixelPkg::subPixelWidth-1:0] s_attrb_tcolor_a;
    logic [pixelPkg::texAddrWidth-1:0] texelAddr;
    logic [pixelPkg::pixelWidth-1:0] texelInput;
    logic m_frag_tready;
    logic [pixelPkg::pixelWidth-1:0] m_frag_tfragmentColor;
    logic [pixelPkg::indexWidth-1:0] m_frag_tindex;
    logic [pixelPkg::screenPosWidth-1:0] m_frag_tscreenPosX;
    logic [pixelPkg::screenPosWidth-1:0] m_frag_tscreenPosY;
    logic [pixelPkg::depthWidth-1:0] m_frag_tdepth;
    logic m_frag_tvalid;
    logic m_frag_tlast;
    logic m_frag_tkeep;

    logic [31:0] texMem [2 ** pixelPkg::texAddrWidth];
    logic [7:0] lutModel [pixelPkg::fogLutDepth];
    expectedFrag_t expected [$];
    expectedFrag_t head;
    logic [31:0] lfsrState = 32'h5390_b808;
    int enabledEdges = 0;
    logic lastEdgeEnabled = 1'b1;
    logic snapshotValid = 1'b0;
    logic [outputBits-1:0] outputSnapshot;
    logic [outputBits-1:0] outputWord;

    tbClock #(.period(clockPeriod), .resetCycles(16)) clockGen (.aclk(aclk), .rstN(rstN));

    pixelPipeline dut0 (
        .aclk(aclk), .rstN(rstN),
        .s_fog_lut_axis_tvalid(s_fog_lut_axis_tvalid),
        .s_fog_lut_axis_tlast(s_fog_lut_axis_tlast),
        .s_fog_lut_axis_tdata(s_fog_lut_axis_tdata),
        .confFeatureEnable(confFeatureEnable),
        .confTextureConfig(confTextureConfig),
        .confTexEnvConfig(confTexEnvConfig),
        .confFogColor(confFogColor),
        .s_attrb_tready(s_attrb_tready),
        .s_attrb_tvalid(s_attrb_tvalid),
        .s_attrb_tlast(s_attrb_tlast),
        .s_attrb_tkeep(s_attrb_tkeep),
        .s_attrb_tspx(s_attrb_tspx),
        .s_attrb_tspy(s_attrb_tspy),
        .s_attrb_tindex(s_attrb_tindex),
        .s_attrb_tdepth_z(s_attrb_tdepth_z),
        .s_attrb_ttexture_s(s_attrb_ttexture_s),
        .s_attrb_ttexture_t(s_attrb_ttexture_t),
        .s_attrb_tcolor_r(s_attrb_tcolor_r),
        .s_attrb_tcolor_g(s_attrb_tcolor_g),
        .s_attrb_tcolor_b(s_attrb_tcolor_b),
        .s_attrb_tcolor_a(s_attrb_tcolor_a),
        .texelAddr(texelAddr),
        .texelInput(texelInput),
        .m_frag_tready(m_frag_tready),
        .m_frag_tfragmentColor(m_frag_tfragmentColor),
        .m_frag_tindex(m_frag_tindex),
        .m_frag_tscreenPosX(m_frag_tscreenPosX),
        .m_frag_tscreenPosY(m_frag_tscreenPosY),
        .m_frag_tdepth(m_frag_tdepth),
        .m_frag_tvalid(m_frag_tvalid),
        .m_frag_tlast(m_frag_tlast),
        .m_frag_tkeep(m_frag_tkeep)
    );

    // Asynchronous texture memory
    assign texelInput = texMem[texelAddr];

    assign outputWord = {m_frag_tfragmentColor, m_frag_tindex, m_frag_tscreenPosX,
                         m_frag_tscreenPosY, m_frag_tdepth, m_frag_tvalid, m_frag_tlast,
                         m_frag_tkeep};

    //////////////////////////////
    // Error handling and random
    //////////////////////////////
    task automatic abortRun(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] expectedValue,
                              input logic [31:0] actualValue);
        assert (actualValue === expectedValue)
        else abortRun($sformatf("FAILED %s expected 0x%0h got 0x%0h", name, expectedValue,
                                actualValue));
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] nextLfsr(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            lfsrState = nextLfsr(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    //////////////////////////////
    // Reference model
    //////////////////////////////
    // Row above column with both cut from the 15 fraction bits
    function automatic logic [pixelPkg::texAddrWidth-1:0] texelAddress(
        input logic [31:0] s, input logic [31:0] t, input logic [3:0] w, input logic [3:0] h);
        logic [31:0] column;
        logic [31:0] row;
        column = 32'(s[14:0]) >> (15 - int'(w));
        row    = 32'(t[14:0]) >> (15 - int'(h));
        return pixelPkg::texAddrWidth'((row << w) | column);
    endfunction

    function automatic logic [31:0] combineModel(input logic texOn, input logic [1:0] mode,
                                                 input logic [31:0] texel,
                                                 input logic [31:0] primary);
        int texelChannel;
        int primaryChannel;
        int value;
        logic [31:0] result;
        if (!texOn)
        begin
            return primary;
        end
        for (int ch = 0; ch < 4; ch++)
        begin
            texelChannel   = int'(texel[ch * 8 +: 8]);
            primaryChannel = int'(primary[ch * 8 +: 8]);
            case (mode)
                pixelPkg::texEnvModulate: value = (texelChannel * primaryChannel) >> 8;
                pixelPkg::texEnvAdd:      value = texelChannel + primaryChannel;
                default:                  value = texelChannel;
            endcase
            result[ch * 8 +: 8] = (value > 255) ? 8'hff : 8'(value);
        end
        return result;
    endfunction

    function automatic logic [31:0] fogModel(input logic fogOn, input logic [31:0] color,
                                             input logic [31:0] fogColor,
                                             input logic [31:0] depth);
        int factor;
        int value;
        logic [31:0] result;
        if (!fogOn)
        begin
            return color;
        end
        // Low six integer bits of the depth
        factor = int'(lutModel[depth[21:16]]);
        for (int ch = 0; ch < 4; ch++)
        begin
            value = factor * int'(color[ch * 8 +: 8])
                    + (255 - factor) * int'(fogColor[ch * 8 +: 8]);
            result[ch * 8 +: 8] = 8'(value >> 8);
        end
        return result;
    endfunction

    //////////////////////////////
    // Stimulus
    //////////////////////////////
    task automatic loadFogTable(input int words);
        logic [31:0] word;
        for (int w = 0; w < words; w++)
        begin
            word = randomBits(32);
            @(posedge aclk);
            #driveDelay;
            s_fog_lut_axis_tvalid = 1'b1;
            s_fog_lut_axis_tlast  = (w == words - 1);
            s_fog_lut_axis_tdata  = word;
            for (int i = 0; i < 4; i++)
            begin
                lutModel[w * 4 + i] = word[i * 8 +: 8];
            end
        end
        @(posedge aclk);
        #driveDelay;
        s_fog_lut_axis_tvalid = 1'b0;
        s_fog_lut_axis_tlast  = 1'b0;
    endtask

    task automatic randomizeFragment(input bit sparse);
        s_attrb_tvalid     = sparse ? 1'(randomBits(1)) : 1'b1;
        s_attrb_tlast      = 1'(randomBits(1));
        s_attrb_tkeep      = 1'(randomBits(1));
        s_attrb_tindex     = pixelPkg::indexWidth'(randomBits(pixelPkg::indexWidth));
        s_attrb_tspx       = pixelPkg::screenPosWidth'(randomBits(pixelPkg::screenPosWidth));
        s_attrb_tspy       = pixelPkg::screenPosWidth'(randomBits(pixelPkg::screenPosWidth));
        s_attrb_tdepth_z   = randomBits(32);
        s_attrb_ttexture_s = randomBits(32);
        s_attrb_ttexture_t = randomBits(32);
        s_attrb_tcolor_r   = 8'(randomBits(8));
        s_attrb_tcolor_g   = 8'(randomBits(8));
        s_attrb_tcolor_b   = 8'(randomBits(8));
        s_attrb_tcolor_a   = 8'(randomBits(8));
    endtask

    // One accepted slot with an optional stall of garbage inputs before it
    task automatic driveSlot(input bit sparse, input bit stalls);
        expectedFrag_t item;
        logic [pixelPkg::texAddrWidth-1:0] addr;
        logic [31:0] texColor;
        int stallLen;
        if (stalls && randomBits(2) == 0)
        begin
            stallLen = 1 + int'(randomBits(2));
            repeat (stallLen)
            begin
                @(posedge aclk);
                #driveDelay;
                m_frag_tready = 1'b0;
                randomizeFragment(1'b1);
            end
        end
        @(posedge aclk);
        #driveDelay;
        m_frag_tready = 1'b1;
        randomizeFragment(sparse);
        if (s_attrb_tvalid)
        begin
            addr = texelAddress(s_attrb_ttexture_s, s_attrb_ttexture_t,
                                confTextureConfig[pixelPkg::texWidthLog2Pos +: 4],
                                confTextureConfig[pixelPkg::texHeightLog2Pos +: 4]);
            texColor = combineModel(confFeatureEnable[pixelPkg::featureEnableTexPos],
                                    confTexEnvConfig[pixelPkg::texEnvFuncPos +: 2],
                                    texMem[addr],
                                    {s_attrb_tcolor_r, s_attrb_tcolor_g, s_attrb_tcolor_b,
                                     s_attrb_tcolor_a});
            item.color = fogModel(confFeatureEnable[pixelPkg::featureEnableFogPos], texColor,
                                  confFogColor, s_attrb_tdepth_z);
            item.side.valid   = 1'b1;
            item.side.last    = s_attrb_tlast;
            item.side.keep    = s_attrb_tkeep;
            item.side.index   = s_attrb_tindex;
            item.side.screenX = s_attrb_tspx;
            item.side.screenY = s_attrb_tspy;
            item.side.depth   = s_attrb_tdepth_z;
            item.dueEdge      = enabledEdges + pixelPkg::pipeLatency;
            expected.push_back(item);
        end
    endtask

    task automatic idleSlot();
        @(posedge aclk);
        #driveDelay;
        m_frag_tready  = 1'b1;
        s_attrb_tvalid = 1'b0;
    endtask

    task automatic runPhase(input logic texOn, input logic fogOn, input logic [1:0] mode,
                            input bit sparse, input bit stalls);
        logic [3:0] widthLog2;
        logic [3:0] heightLog2;
        // 2 to 256 texels per side
        widthLog2  = 4'(1 + randomBits(3));
        heightLog2 = 4'(1 + randomBits(3));
        confFeatureEnable = '0;
        confFeatureEnable[pixelPkg::featureEnableTexPos] = texOn;
        confFeatureEnable[pixelPkg::featureEnableFogPos] = fogOn;
        confTextureConfig = '0;
        confTextureConfig[pixelPkg::texWidthLog2Pos +: 4]  = widthLog2;
        confTextureConfig[pixelPkg::texHeightLog2Pos +: 4] = heightLog2;
        confTexEnvConfig = '0;
        confTexEnvConfig[pixelPkg::texEnvFuncPos +: 2] = mode;
        confFogColor = randomBits(32);
        repeat (fragmentsPerPhase) driveSlot(sparse, stalls);
        // Drain before the next config change
        repeat (pixelPkg::pipeLatency + 1) idleSlot();
    endtask

    //////////////////////////////
    // Monitor
    //////////////////////////////
    task automatic compareFragment(input expectedFrag_t item);
        checkValue("m_frag_tvalid", 32'(item.side.valid), 32'(m_frag_tvalid));
        checkValue("m_frag_tfragmentColor", item.color, m_frag_tfragmentColor);
        checkValue("m_frag_tindex", 32'(item.side.index), 32'(m_frag_tindex));
        checkValue("m_frag_tscreenPosX", 32'(item.side.screenX), 32'(m_frag_tscreenPosX));
        checkValue("m_frag_tscreenPosY", 32'(item.side.screenY), 32'(m_frag_tscreenPosY));
        checkValue("m_frag_tdepth", item.side.depth, m_frag_tdepth);
        checkValue("m_frag_tlast", 32'(item.side.last), 32'(m_frag_tlast));
        checkValue("m_frag_tkeep", 32'(item.side.keep), 32'(m_frag_tkeep));
    endtask

    always @(posedge aclk)
    begin
        lastEdgeEnabled = m_frag_tready;
        if (rstN && m_frag_tready)
        begin
            enabledEdges++;
        end
    end

    // Outputs are stable around the falling edge
    always @(negedge aclk)
    begin
        if (!rstN)
        begin
            assert (!m_frag_tvalid) else abortRun("m_frag_tvalid went high during reset");
        end
        else
        begin
            checkValue("s_attrb_tready", 32'(m_frag_tready), 32'(s_attrb_tready));
            if (snapshotValid && !lastEdgeEnabled)
            begin
                assert (outputWord === outputSnapshot)
                else abortRun($sformatf("FAILED m_frag outputs during stall expected 0x%0h got 0x%0h",
                                        outputSnapshot, outputWord));
            end
            outputSnapshot = outputWord;
            snapshotValid  = 1'b1;
            if (m_frag_tready)
            begin
                if (expected.size() > 0 && expected[0].dueEdge == enabledEdges)
                begin
                    head = expected.pop_front();
                    compareFragment(head);
                end
                else
                begin
                    assert (!m_frag_tvalid)
                    else abortRun("m_frag_tvalid high with no fragment due at this edge");
                end
            end
        end
    end

    initial
    begin
        #(watchdogTime);
        abortRun("Watchdog expired before all test phases finished");
    end

    initial
    begin
        logic [31:0] addrWord;
        s_fog_lut_axis_tvalid = 1'b0;
        s_fog_lut_axis_tlast  = 1'b0;
        s_fog_lut_axis_tdata  = '0;
        confFeatureEnable     = '0;
        confTextureConfig     = '0;
        confTexEnvConfig      = '0;
        confFogColor          = '0;
        m_frag_tready         = 1'b1;
        randomizeFragment(1'b0);
        s_attrb_tvalid        = 1'b0;
        // Pattern mixes every address bit
        for (int a = 0; a < 2 ** pixelPkg::texAddrWidth; a++)
        begin
            addrWord  = 32'(a);
            texMem[a] = (addrWord * 32'h9e37_79b1) ^ (addrWord << 15);
        end
        @(posedge rstN);
        // Short load ends on tlast part way through the table
        loadFogTable(5);
        runPhase(1'b1, 1'b0, pixelPkg::texEnvReplace, 1'b0, 1'b0);
        runPhase(1'b1, 1'b0, pixelPkg::texEnvModulate, 1'b0, 1'b0);
        runPhase(1'b1, 1'b0, pixelPkg::texEnvAdd, 1'b0, 1'b0);
        runPhase(1'b0, 1'b0, pixelPkg::texEnvModulate, 1'b0, 1'b0);
        // Full load lines up with the model only if tlast cleared the pointer
        loadFogTable(pixelPkg::fogLutDepth / 4);
        runPhase(1'b0, 1'b1, pixelPkg::texEnvReplace, 1'b0, 1'b0);
        runPhase(1'b1, 1'b1, pixelPkg::texEnvModulate, 1'b1, 1'b0);
        runPhase(1'b1, 1'b1, pixelPkg::texEnvAdd, 1'b1, 1'b1);
        runPhase(1'b1, 1'b0, pixelPkg::texEnvReplace, 1'b1, 1'b1);
        repeat (2) @(posedge aclk);
        if (expected.size() == 0)
        begin
            $display("All tests passed");
            $finish;
        end
        else
        begin
            abortRun("Fragments were accepted but never reached the output");
        end
    end

endmodule

//--- pixelPipeline.f
pixelPkg.sv
valueDelay.sv
textureStage.sv
fogLut.sv
fogStage.sv
pixelPipeline.sv
tbClock.sv
pixelPipelineTb.sv

//--- run.sh
#!/bin/sh
# Build and run the pixel pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module pixelPipelineTb \
    -f pixelPipeline.f -o simPixelPipeline
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simPixelPipeline > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
